/* flist.f */
+incdir+sim
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/fetch_fifo.sv
hdl/prefetch_ctrl.sv
hdl/fetch_unit_top.sv
sim/clk_rst_gen.sv
sim/imem_model.sv
sim/fetch_properties.sv
sim/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module fetch_tb -o fetch_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/fetch_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
  exit 0
fi
exit 1

/* sim/fetch_ref.svh */
// reference functions of the fetch testbench: memory contents and the Galois LFSR step

  // instruction word stored at an address, a fixed function of the word index
  function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::addr_t addr);
    logic [31:0] idx;
    idx = {2'b00, addr[31:2]};
    return (idx * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

/* sim/fetch_tb.sv */
// testbench top of the fetch front end with memory model, stream checker and scenarios
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

`include "fetch_ref.svh"

  logic                    clk;
  logic                    rst_n;
  logic                    flush;
  fetch_pkg::addr_t        redirect;
  logic                    en;
  logic                    ready;
  fetch_pkg::imem_req_t    imem_req;
  logic                    gnt;
  fetch_pkg::instr_t       rdata;
  logic                    rvalid;
  logic                    valid;
  fetch_pkg::fetch_entry_t entry;
  logic                    busy;

  // stall control and checker state
  logic                    stall_en;
  logic                    ready_hold;
  logic [15:0]             lfsr;
  fetch_pkg::addr_t        exp_addr;
  int unsigned             xfers;
  logic                    prev_stall;
  fetch_pkg::fetch_entry_t prev_entry;
  // granted memory request still waiting for its response
  logic                    mem_outst;

  clk_rst_gen clk_gen_i (.clk_o(clk), .rst_no(rst_n));

  imem_model imem_i (
    .clk_i(clk), .rst_ni(rst_n), .req_i(imem_req),
    .gnt_o(gnt), .rdata_o(rdata), .rvalid_o(rvalid)
  );

  fetch_unit_top #(.FIFO_DEPTH(4)) dut_i (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush), .redirect_addr_i(redirect),
    .en_i(en), .imem_req_o(imem_req), .instr_gnt_i(gnt), .instr_rdata_i(rdata),
    .instr_rvalid_i(rvalid), .valid_o(valid), .fetch_entry_o(entry),
    .ready_i(ready), .busy_o(busy)
  );

  // ------------------------------------------------------------
  // reporting and compare tasks
  // ------------------------------------------------------------
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_entry(input fetch_pkg::fetch_entry_t got,
                             input fetch_pkg::fetch_entry_t exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED at %0t: entry addr %h instr %h, expected addr %h instr %h",
                         $time, got.addr, got.instr, exp.addr, exp.instr));
    end
  endtask

  task automatic check_hold(input fetch_pkg::fetch_entry_t got,
                            input fetch_pkg::fetch_entry_t held);
    if (got !== held) begin
      fail_now($sformatf("FAILED at %0t: entry changed during stall, %h became %h",
                         $time, held, got));
    end
  endtask

  // ready_i source, random stalls or a fixed level
  always @(posedge clk) begin
    if (stall_en) begin
      ready <= lfsr[0];
      lfsr  <= lfsr_step(lfsr);
    end else begin
      ready <= ready_hold;
    end
  end

  // memory bus tracker, set on a grant and cleared by the response
  always @(posedge clk) begin
    if (!rst_n) begin
      mem_outst <= 1'b0;
    end else if (imem_req.req && gnt) begin
      mem_outst <= 1'b1;
    end else if (rvalid) begin
      mem_outst <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // stream checker
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      if (prev_stall && !flush) begin
        if (!valid) begin
          fail_now($sformatf("FAILED at %0t: valid_o dropped during stall", $time));
        end
        check_hold(entry, prev_entry);
      end
      if (valid && ready) begin
        check_entry(entry, '{addr: exp_addr, instr: mem_word(exp_addr)});
        exp_addr = exp_addr + 4;
        xfers    <= xfers + 1;
      end
      // the new stream starts at the aligned target
      if (flush) begin
        exp_addr = {redirect[63:2], 2'b00};
      end
      prev_stall = valid && !ready && !flush;
      prev_entry = entry;
    end
  end

  // ------------------------------------------------------------
  // wait helpers
  // ------------------------------------------------------------
  task automatic wait_transfers(input int unsigned n);
    int unsigned target;
    int unsigned t;
    target = xfers + n;
    t = 0;
    while (xfers < target) begin
      @(posedge clk);
      t++;
      if (t > 2000) fail_now("timeout waiting for fetched entries");
    end
  endtask

  task automatic issue_flush(input fetch_pkg::addr_t target);
    flush    <= 1'b1;
    redirect <= target;
    @(posedge clk);
    flush    <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // scenarios
  // ------------------------------------------------------------
  initial begin
    int unsigned t;
    flush      = 1'b0;
    redirect   = '0;
    en         = 1'b0;
    ready      = 1'b0;
    stall_en   = 1'b0;
    ready_hold = 1'b1;
    lfsr       = 16'd87;
    exp_addr   = '0;
    xfers      = 0;
    prev_stall = 1'b0;
    prev_entry = '0;
    t = 0;
    while (!rst_n) begin
      @(posedge clk);
      t++;
      if (t > 50) fail_now("reset never released");
    end
    @(posedge clk);
    if (imem_req.req || valid || busy) fail_now("outputs not idle after reset");

    // sequential stream, then random stalls
    en <= 1'b1;
    wait_transfers(32);
    stall_en <= 1'b1;
    wait_transfers(40);

    // flush to an unaligned target while a request is in flight
    t = 0;
    while (!imem_req.req) begin
      @(posedge clk);
      t++;
      if (t > 100) fail_now("timeout waiting for a memory request");
    end
    issue_flush(64'h0000_1002);
    wait_transfers(20);

    // two flushes one cycle apart
    flush    <= 1'b1;
    redirect <= 64'h0000_2000;
    @(posedge clk);
    issue_flush(64'h0000_3006);
    wait_transfers(20);

    // fetch disabled, last response lands and the FIFO drains
    en <= 1'b0;
    t = 0;
    while (imem_req.req || mem_outst || rvalid || valid) begin
      @(posedge clk);
      t++;
      if (t > 200) fail_now("fetch did not stop with en_i low");
    end
    repeat (20) begin
      @(posedge clk);
      if (valid || imem_req.req) fail_now("activity while fetch disabled");
    end
    en <= 1'b1;
    wait_transfers(10);

    // decoder stalled, FIFO fills and requests stop
    stall_en   <= 1'b0;
    ready_hold <= 1'b0;
    t = 0;
    @(posedge clk);
    while (ready || !busy || imem_req.req) begin
      @(posedge clk);
      t++;
      if (t > 100) fail_now("busy_o did not rise with a full FIFO");
    end
    repeat (20) begin
      @(posedge clk);
      if (imem_req.req) fail_now("request issued while the FIFO is full");
      if (!busy) fail_now("busy_o fell while the FIFO is full");
    end
    ready_hold <= 1'b1;
    wait_transfers(10);

    $display("all tests passed");
    $finish;
  end

  // overall bound on the run
  initial begin
    #200000;
    fail_now("simulation timeout");
  end

endmodule

`default_nettype wire

/* sim/fetch_properties.sv */
// protocol and FIFO assertions for the fetch front end, bound to the top level
`timescale 1ns/100ps
`default_nettype none

module fetch_properties (
  input wire logic            clk_i,
  input wire logic            rst_ni,
  input wire logic            flush_i,
  input fetch_pkg::imem_req_t imem_req_o,
  input wire logic            instr_gnt_i,
  input wire logic            instr_rvalid_i,
  input wire logic            valid_o
);

  // one granted request waiting for its response
  logic outst_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= 1'b0;
    end else if (imem_req_o.req && instr_gnt_i) begin
      outst_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      outst_q <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // rules
  // ----------------------------------------------------------
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_req_o.req && !instr_gnt_i |=> imem_req_o.req && $stable(imem_req_o.addr))
    else $error("request address changed before the grant");

  rvalid_granted: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> outst_q)
    else $error("rvalid without an outstanding grant");

  flush_empties: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !valid_o)
    else $error("valid_o high in the cycle after a flush");

endmodule

bind fetch_unit_top fetch_properties props_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .flush_i        (flush_i),
  .imem_req_o     (imem_req_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .valid_o        (valid_o)
);

`default_nettype wire

/* sim/imem_model.sv */
// instruction memory model with random grant and response delays on a req/gnt/rvalid bus
`timescale 1ns/100ps
`default_nettype none

module imem_model (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  fetch_pkg::imem_req_t req_i,
  output logic                 gnt_o,
  output fetch_pkg::instr_t    rdata_o,
  output logic                 rvalid_o
);

`include "fetch_ref.svh"

  logic [15:0]      lfsr;
  int unsigned      gnt_cnt;
  int unsigned      rv_cnt;
  logic             pending;
  fetch_pkg::addr_t addr_q;

  // delay of 0 to 3 cycles, one LFSR step per bit
  function automatic int unsigned take_delay();
    int unsigned d;
    d = 0;
    for (int i = 0; i < 2; i++) begin
      d = (d << 1) | lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
    return d;
  endfunction

  // grant comes when the wait counter has run out
  assign gnt_o = req_i.req && (gnt_cnt == 0);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr     = 16'd87;
      gnt_cnt  <= 0;
      rv_cnt   <= 0;
      pending  <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      addr_q   <= '0;
    end else begin
      rvalid_o <= 1'b0;
      // response side
      if (pending) begin
        if (rv_cnt == 0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem_word(addr_q);
          pending  <= 1'b0;
        end else begin
          rv_cnt <= rv_cnt - 1;
        end
      end
      // request side
      if (req_i.req && gnt_o) begin
        addr_q  <= req_i.addr;
        pending <= 1'b1;
        rv_cnt  <= take_delay();
        gnt_cnt <= take_delay();
      end else if (req_i.req && gnt_cnt != 0) begin
        gnt_cnt <= gnt_cnt - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* sim/clk_rst_gen.sv */
// testbench clock and reset source, 10 ns clock and 5 cycles of reset
`timescale 1ns/100ps
`default_nettype none

module clk_rst_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* hdl/fetch_unit_top.sv */
// instruction fetch front end, PC generator and prefetch FSM feeding the fetch FIFO
`timescale 1ns/100ps
`default_nettype none

module fetch_unit_top #(
  // entries buffered towards the decoder, power of two
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  // redirect
  input  wire logic               flush_i,
  input  fetch_pkg::addr_t        redirect_addr_i,
  input  wire logic               en_i,
  // instruction memory
  output fetch_pkg::imem_req_t    imem_req_o,
  input  wire logic               instr_gnt_i,
  input  fetch_pkg::instr_t       instr_rdata_i,
  input  wire logic               instr_rvalid_i,
  // decoder
  output logic                    valid_o,
  output fetch_pkg::fetch_entry_t fetch_entry_o,
  input  wire logic               ready_i,
  output logic                    busy_o
);

  // ----------------------------------------------------------
  // internal wires
  // ----------------------------------------------------------
  fetch_pkg::addr_t        pc;
  logic                    pc_take;
  logic                    push_valid;
  logic                    push_ready;
  fetch_pkg::fetch_entry_t push_entry;

  // fetch address register
  fetch_pc_gen pc_gen_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .redirect_addr_i (redirect_addr_i),
    .pc_take_i       (pc_take),
    .pc_o            (pc)
  );

  // memory side FSM
  prefetch_ctrl ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .en_i           (en_i),
    .pc_i           (pc),
    .pc_take_o      (pc_take),
    .imem_req_o     (imem_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .push_ready_i   (push_ready),
    .push_valid_o   (push_valid),
    .push_entry_o   (push_entry),
    .busy_o         (busy_o)
  );

  // flush also clears the buffered entries
  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (flush_i),
    .in_valid_i  (push_valid),
    .in_entry_i  (push_entry),
    .in_ready_o  (push_ready),
    .out_valid_o (valid_o),
    .out_entry_o (fetch_entry_o),
    .out_ready_i (ready_i)
  );

endmodule

`default_nettype wire

/* hdl/prefetch_ctrl.sv */
// prefetch FSM, issues instruction memory requests and pushes the responses into the fetch FIFO
`timescale 1ns/100ps
`default_nettype none

module prefetch_ctrl (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               flush_i,
  // fetch enable from the core
  input  wire logic               en_i,
  // program counter interface
  input  fetch_pkg::addr_t        pc_i,
  output logic                    pc_take_o,
  // instruction memory, req/gnt/rvalid
  output fetch_pkg::imem_req_t    imem_req_o,
  input  wire logic               instr_gnt_i,
  input  fetch_pkg::instr_t       instr_rdata_i,
  input  wire logic               instr_rvalid_i,
  // FIFO push interface
  input  wire logic               push_ready_i,
  output logic                    push_valid_o,
  output fetch_pkg::fetch_entry_t push_entry_o,
  // status
  output logic                    busy_o
);

  fetch_pkg::fetch_state_e state_q;
  fetch_pkg::fetch_state_e state_d;

  // address of the request in flight, paired with rdata on return
  fetch_pkg::addr_t addr_q;
  // flush arrived while still waiting for the grant
  logic             abort_q;
  logic             can_req;
  logic             issue;

  // no new request in a flush cycle, pc still holds the old stream there
  assign can_req = en_i && push_ready_i && !flush_i;

  // ----------------------------------------------------------
  // next state and request logic
  // ----------------------------------------------------------
  always_comb begin
    state_d         = state_q;
    issue           = 1'b0;
    imem_req_o.req  = 1'b0;
    imem_req_o.addr = pc_i;
    push_valid_o    = 1'b0;

    unique case (state_q)
      // nothing outstanding
      fetch_pkg::IDLE: begin
        if (can_req) begin
          issue = 1'b1;
        end
      end

      // request raised, address held from addr_q until granted
      fetch_pkg::WAIT_GNT: begin
        imem_req_o.req  = 1'b1;
        imem_req_o.addr = addr_q;
        if (instr_gnt_i) begin
          // a flush now or earlier makes the response stale
          if (flush_i || abort_q) begin
            state_d = fetch_pkg::WAIT_ABORTED;
          end else begin
            state_d = fetch_pkg::WAIT_RVALID;
          end
        end
      end

      // one response outstanding
      fetch_pkg::WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          // a response in the flush cycle belongs to the old stream
          push_valid_o = !flush_i;
          state_d      = fetch_pkg::IDLE;
          // back to back, next request in the rvalid cycle
          if (can_req) begin
            issue = 1'b1;
          end
        end else if (flush_i) begin
          state_d = fetch_pkg::WAIT_ABORTED;
        end
      end

      // outstanding response is dropped when it arrives
      fetch_pkg::WAIT_ABORTED: begin
        if (instr_rvalid_i) begin
          state_d = fetch_pkg::IDLE;
          if (can_req) begin
            issue = 1'b1;
          end
        end
      end

      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase

    // start a new request from pc, granted at once or waiting for it
    if (issue) begin
      imem_req_o.req = 1'b1;
      if (instr_gnt_i) begin
        state_d = fetch_pkg::WAIT_RVALID;
      end else begin
        state_d = fetch_pkg::WAIT_GNT;
      end
    end
  end

  // pc moves on as soon as its address is in addr_q
  assign pc_take_o = issue;

  // returned word paired with the address it was fetched from
  assign push_entry_o.addr  = addr_q;
  assign push_entry_o.instr = instr_rdata_i;

  // ----------------------------------------------------------
  // status
  // ----------------------------------------------------------
  assign busy_o = (state_q == fetch_pkg::WAIT_GNT) ||
                  (state_q == fetch_pkg::WAIT_ABORTED) ||
                  !push_ready_i;

  // ----------------------------------------------------------
  // registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= fetch_pkg::IDLE;
      abort_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // only set while waiting for a grant, cleared when it arrives
      if (state_q == fetch_pkg::WAIT_GNT) begin
        if (instr_gnt_i) begin
          abort_q <= 1'b0;
        end else if (flush_i) begin
          abort_q <= 1'b1;
        end
      end
    end
  end

  // request address
  always_ff @(posedge clk_i) begin
    if (issue) begin
      addr_q <= pc_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_fifo.sv */
// circular buffer of fetch entries between the prefetch controller and the decoder
`timescale 1ns/100ps
`default_nettype none

module fetch_fifo #(
  // power of two, at least 2
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  // flush, empties the buffer in one cycle
  input  wire logic              clear_i,
  // push side, from the controller
  input  wire logic              in_valid_i,
  input  fetch_pkg::fetch_entry_t in_entry_i,
  output logic                   in_ready_o,
  // pop side, to the decoder
  output logic                   out_valid_o,
  output fetch_pkg::fetch_entry_t out_entry_o,
  input  wire logic              out_ready_i
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(FIFO_DEPTH);

  // ----------------------------------------------------------
  // storage and pointers
  // ----------------------------------------------------------
  fetch_pkg::fetch_entry_t mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count_q == FULL_CNT);

  // head entry holds while the decoder stalls, writes only go to free slots
  assign out_valid_o = (count_q != '0);
  assign out_entry_o = mem_q[rd_ptr_q];
  assign pop         = out_valid_o && out_ready_i;

  // ready drops one slot early
  // the controller starts a request only with ready high, so the one
  // response still in flight always finds a free slot
  assign in_ready_o = (count_q < (FULL_CNT - 1'b1));

  // a full buffer still takes a push when the head leaves in the same cycle
  assign push = in_valid_i && (!full || pop);

  // ----------------------------------------------------------
  // control registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      // flush drops everything, including a push in this cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap by overflow since the depth is a power of two
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_entry_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_pc_gen.sv */
// fetch program counter, steps by one word per taken address and jumps on a flush
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_gen (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  // redirect from the back end
  input  wire logic           flush_i,
  input  fetch_pkg::addr_t    redirect_addr_i,
  // controller has issued the current address
  input  wire logic           pc_take_i,
  // address for the next request
  output fetch_pkg::addr_t    pc_o
);

  // ----------------------------------------------------------
  // next address
  // ----------------------------------------------------------
  fetch_pkg::addr_t pc_q;
  fetch_pkg::addr_t pc_d;
  fetch_pkg::addr_t redirect_aligned;
  fetch_pkg::addr_t pc_incr;

  // only word aligned fetch is supported, so drop the low bits of the target
  assign redirect_aligned = {redirect_addr_i[fetch_pkg::ADDR_W-1:2], 2'b00};

  // sequential successor, one 32-bit instruction further
  assign pc_incr = pc_q + fetch_pkg::addr_t'(4);

  always_comb begin
    pc_d = pc_q;
    // a redirect wins over a take in the same cycle
    if (flush_i) begin
      pc_d = redirect_aligned;
    end else if (pc_take_i) begin
      pc_d = pc_incr;
    end
  end

  // ----------------------------------------------------------
  // register
  // ----------------------------------------------------------

  // fetch starts at address zero out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

/* hdl/fetch_pkg.sv */
// shared types of the instruction fetch front end: widths, fetch entry, memory request, FSM states
`default_nettype none

package fetch_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------

  // instruction address width of the 64-bit core
  localparam int unsigned ADDR_W  = 64;
  // uncompressed instructions only
  localparam int unsigned INSTR_W = 32;

  // ----------------------------------------------------------
  // basic types
  // ----------------------------------------------------------

  // word aligned wherever it is issued, bits 1 and 0 stay zero
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [INSTR_W-1:0] instr_t;

  // ----------------------------------------------------------
  // structs
  // ----------------------------------------------------------

  // one fetched instruction with the address it came from, 96 bits
  typedef struct packed {
    addr_t  addr;
    instr_t instr;
  } fetch_entry_t;

  // request side of the req/gnt/rvalid instruction memory bus
  typedef struct packed {
    logic  req;
    addr_t addr;
  } imem_req_t;

  // ----------------------------------------------------------
  // prefetch controller states
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } fetch_state_e;

endpackage

`default_nettype wire
